// File: verilog/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// clocks per bit, 2 or more.
`define UART_CLKS_PER_BIT 4

// start, eight data bits, parity, stop.
`define UART_FRAME_BITS 11

`endif

// File: verilog/uart_pkg.sv
package uart_pkg;

   typedef logic [7:0] uart_byte_t;

   typedef logic [15:0] uart_cmd_t;  // high byte goes out first.

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_HI,
      TX_LO
   } tx_state_e;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_BITS,
      RX_STOP
   } rx_state_e;

   typedef enum logic [1:0] {
      RX_OK,
      RX_PARITY_ERR,
      RX_STOP_ERR
   } rx_status_e;

   // parity bit that makes data plus parity hold an odd number of ones.
   function automatic logic odd_parity(input uart_byte_t d);
      return ~(^d);
   endfunction

endpackage

// File: verilog/uart_if.sv
interface uart_tx_if;
   uart_pkg::uart_byte_t data;
   logic                 load;  // one-cycle strobe while busy is low.
   logic                 busy;
   logic                 done;  // one cycle at the end of the stop bit.

   modport ctrl (
      output data,
      output load,
      input  busy,
      input  done
   );

   modport shifter (
      input  data,
      input  load,
      output busy,
      output done
   );
endinterface

interface uart_rx_if;
   uart_pkg::uart_byte_t data;
   uart_pkg::rx_status_e status;
   logic                 vld;  // data and status valid with it.

   modport deser (
      output data,
      output status,
      output vld
   );

   modport ctrl (
      input data,
      input status,
      input vld
   );
endinterface

// File: verilog/uart_ctrl.sv
module uart_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  uart_pkg::uart_cmd_t  cmd_in,
   input  logic                 cmd_vld,
   output logic                 cmd_rdy,
   uart_tx_if.ctrl              txc,
   uart_rx_if.ctrl              rxc,
   output logic                 read_rdy,
   output uart_pkg::uart_byte_t read_data,
   output logic                 read_err
);

   uart_pkg::tx_state_e state;
   uart_pkg::uart_cmd_t cmd_q;
   logic                accept;
   logic                rx_ok;

   assign accept = cmd_vld && cmd_rdy;
   assign rx_ok  = (rxc.status == uart_pkg::RX_OK);

   // the shifter takes the byte in the cycle that load is high.
   assign txc.data = (state == uart_pkg::TX_LO) ? cmd_q[7:0] : cmd_q[15:8];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= uart_pkg::TX_IDLE;
         txc.load <= 1'b0;
         cmd_rdy  <= 1'b1;
      end else begin
         txc.load <= 1'b0;
         case (state)
            uart_pkg::TX_IDLE: begin
               if (accept) begin
                  state    <= uart_pkg::TX_HI;
                  txc.load <= 1'b1;
                  cmd_rdy  <= 1'b0;
               end else if (!cmd_rdy) begin
                  cmd_rdy <= 1'b1;  // low byte stop bit has just ended.
               end
            end
            uart_pkg::TX_HI: begin
               if (txc.done) begin
                  state    <= uart_pkg::TX_LO;
                  txc.load <= 1'b1;  // lands on the last stop-bit cycle.
               end
            end
            uart_pkg::TX_LO: begin
               if (txc.done) begin
                  state <= uart_pkg::TX_IDLE;
               end
            end
            default: state <= uart_pkg::TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_q <= cmd_in;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_rdy <= 1'b0;
         read_err <= 1'b0;
      end else begin
         read_rdy <= rxc.vld && rx_ok;
         read_err <= rxc.vld && !rx_ok;
      end
   end

   // bad frames leave the last good byte in place.
   always_ff @(posedge clk) begin
      if (rxc.vld && rx_ok) begin
         read_data <= rxc.data;
      end
   end

endmodule

// File: verilog/uart_tx_shifter.sv
`include "uart_cfg.svh"

module uart_tx_shifter (
   input  logic        clk,
   input  logic        rst_n,
   uart_tx_if.shifter  txs,
   output logic        tx
);

   localparam int CPB  = `UART_CLKS_PER_BIT;
   localparam int CW   = $clog2(CPB);
   localparam int NB   = `UART_FRAME_BITS;
   localparam int LAST = NB - 1;

   logic [NB-2:0] frame;  // bits still to go after the start bit.
   logic [CW-1:0] cnt;
   logic [3:0]    bit_idx;
   logic          busy_q;
   logic          bit_end;

   assign bit_end = (cnt == CW'(CPB - 1));

   // one cycle before the stop bit ends, so the next load meets its last cycle.
   assign txs.done = busy_q && (bit_idx == 4'(LAST)) && (cnt == CW'(CPB - 2));
   assign txs.busy = busy_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx      <= 1'b1;
         busy_q  <= 1'b0;
         cnt     <= '0;
         bit_idx <= '0;
      end else if (txs.load) begin
         tx      <= 1'b0;  // start bit.
         busy_q  <= 1'b1;
         cnt     <= '0;
         bit_idx <= '0;
      end else if (busy_q) begin
         if (txs.done) begin
            busy_q <= 1'b0;  // tx already high for the stop bit.
         end else if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 4'd1;
            tx      <= frame[NB-2];
         end else begin
            cnt <= cnt + CW'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (txs.load) begin
         frame <= {txs.data, uart_pkg::odd_parity(txs.data), 1'b1};
      end else if (busy_q && bit_end) begin
         frame <= {frame[NB-3:0], 1'b1};
      end
   end

endmodule

// File: verilog/uart_rx_deser.sv
`include "uart_cfg.svh"

module uart_rx_deser (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      rx,
   uart_rx_if.deser  rxs
);

   localparam int CPB   = `UART_CLKS_PER_BIT;
   localparam int CW    = $clog2(CPB);
   localparam int HALF  = CPB / 2;
   localparam int NBITS = `UART_FRAME_BITS - 2;  // data plus parity.

   logic                 rx_s1;
   logic                 rx_s2;
   logic                 rx_s3;
   uart_pkg::rx_state_e  state;
   logic [CW-1:0]        cnt;
   logic [3:0]           bit_idx;
   logic [NBITS-1:0]     shreg;
   logic                 bit_end;
   uart_pkg::uart_byte_t rx_byte;

   assign bit_end = (cnt == CW'(CPB - 1));
   assign rx_byte = shreg[NBITS-1:1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_s1 <= 1'b1;
         rx_s2 <= 1'b1;
         rx_s3 <= 1'b1;
      end else begin
         rx_s1 <= rx;
         rx_s2 <= rx_s1;
         rx_s3 <= rx_s2;  // edge history.
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= uart_pkg::RX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         rxs.vld <= 1'b0;
      end else begin
         rxs.vld <= 1'b0;
         case (state)
            uart_pkg::RX_IDLE: begin
               if (rx_s3 && !rx_s2) begin
                  state <= uart_pkg::RX_START;
                  cnt   <= '0;
               end
            end
            uart_pkg::RX_START: begin
               if (cnt == CW'(HALF - 1)) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= rx_s2 ? uart_pkg::RX_IDLE : uart_pkg::RX_BITS;  // glitch.
               end else begin
                  cnt <= cnt + CW'(1);
               end
            end
            uart_pkg::RX_BITS: begin
               if (bit_end) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 4'd1;
                  if (bit_idx == 4'(NBITS - 1)) begin
                     state <= uart_pkg::RX_STOP;
                  end
               end else begin
                  cnt <= cnt + CW'(1);
               end
            end
            uart_pkg::RX_STOP: begin
               if (bit_end) begin
                  state   <= uart_pkg::RX_IDLE;
                  rxs.vld <= 1'b1;
               end else begin
                  cnt <= cnt + CW'(1);
               end
            end
            default: state <= uart_pkg::RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == uart_pkg::RX_BITS && bit_end) begin
         shreg <= {shreg[NBITS-2:0], rx_s2};  // msb arrives first.
      end
      if (state == uart_pkg::RX_STOP && bit_end) begin
         rxs.data <= rx_byte;
         if (uart_pkg::odd_parity(rx_byte) != shreg[0]) begin
            rxs.status <= uart_pkg::RX_PARITY_ERR;
         end else if (!rx_s2) begin
            rxs.status <= uart_pkg::RX_STOP_ERR;
         end else begin
            rxs.status <= uart_pkg::RX_OK;
         end
      end
   end

endmodule

// File: verilog/uart_top.sv
module uart_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  uart_pkg::uart_cmd_t  cmd_in,
   input  logic                 cmd_vld,
   input  logic                 rx,
   output logic                 tx,
   output logic                 cmd_rdy,
   output logic                 read_rdy,
   output uart_pkg::uart_byte_t read_data,
   output logic                 read_err
);

   uart_tx_if u_tx_if ();
   uart_rx_if u_rx_if ();

   uart_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .txc       (u_tx_if.ctrl),
      .rxc       (u_rx_if.ctrl),
      .read_rdy  (read_rdy),
      .read_data (read_data),
      .read_err  (read_err)
   );

   uart_tx_shifter u_tx_shifter (
      .clk   (clk),
      .rst_n (rst_n),
      .txs   (u_tx_if.shifter),
      .tx    (tx)
   );

   uart_rx_deser u_rx_deser (
      .clk   (clk),
      .rst_n (rst_n),
      .rx    (rx),
      .rxs   (u_rx_if.deser)
   );

endmodule

// File: tests/uart_properties.sv
module uart_properties (
   input logic clk,
   input logic rst_n,
   input logic load,
   input logic busy,
   input logic tx,
   input logic cmd_vld,
   input logic cmd_rdy,
   input logic read_rdy,
   input logic read_err
);

   a_load_idle: assert property (@(posedge clk) disable iff (!rst_n) load |-> !busy)
      else $error("load issued while the shifter is busy");

   a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx)
      else $error("tx low while the shifter is idle");

   // each receive result is a single-cycle strobe.
   a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                  (read_rdy || read_err) |=> !(read_rdy || read_err))
      else $error("read strobe held for more than one cycle");

   // accepted command takes cmd_rdy low on the next cycle.
   a_rdy_fall: assert property (@(posedge clk) disable iff (!rst_n)
                                cmd_vld && cmd_rdy |=> !cmd_rdy)
      else $error("cmd_rdy still high after an accepted command");

endmodule

bind uart_top uart_properties u_properties (
   .clk      (clk),
   .rst_n    (rst_n),
   .load     (u_tx_if.load),
   .busy     (u_tx_if.busy),
   .tx       (tx),
   .cmd_vld  (cmd_vld),
   .cmd_rdy  (cmd_rdy),
   .read_rdy (read_rdy),
   .read_err (read_err)
);

// File: tests/tb_uart_top.sv
`include "uart_cfg.svh"

module tb_uart_top;

   localparam int CPB         = `UART_CLKS_PER_BIT;
   localparam int FB          = `UART_FRAME_BITS;
   localparam int CMD_CYCLES  = 2 * FB * CPB + 2;  // acceptance to cmd_rdy seen high.
   localparam int NUM_LOOP    = 40;
   localparam int NUM_INJ     = 20;
   localparam int CYCLE_LIMIT = 20000;  // 40 x 90 plus 20 x 50, with margin.

   typedef struct packed {
      uart_pkg::uart_byte_t data;
      uart_pkg::rx_status_e status;
   } rx_exp_t;

   logic                 clk;
   logic                 rst_n;
   uart_pkg::uart_cmd_t  cmd_in;
   logic                 cmd_vld;
   logic                 rx;
   logic                 tx;
   logic                 cmd_rdy;
   logic                 read_rdy;
   uart_pkg::uart_byte_t read_data;
   logic                 read_err;
   logic                 loopback;
   logic                 bb_line;

   rx_exp_t              exp_q[$];
   rx_exp_t              got_exp;
   uart_pkg::uart_byte_t last_good;
   logic [31:0]          seed = 32'h3c4d_ee81;
   int                   cycle_count = 0;
   int                   err_count = 0;
   int                   check_count = 0;
   int                   tests_run = 0;
   int                   tests_failed = 0;
   int                   test_err_base = 0;

   assign rx = loopback ? tx : bb_line;

   uart_top u_uart_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .rx        (rx),
      .tx        (tx),
      .cmd_rdy   (cmd_rdy),
      .read_rdy  (read_rdy),
      .read_data (read_data),
      .read_err  (read_err)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: run stopped after %0d cycles", cycle_count);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      seed = xorshift32(seed);
      return seed;
   endfunction

   // odd parity by counting ones.
   function automatic logic parity_bit(input uart_pkg::uart_byte_t d);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) begin
         if (d[i]) begin
            ones++;
         end
      end
      return (ones % 2 == 0);
   endfunction

   function automatic logic [FB-1:0] frame_bits(input uart_pkg::uart_byte_t d,
                                                input logic par, input logic stop);
      return {1'b0, d, par, stop};
   endfunction

   function automatic uart_pkg::rx_status_e frame_status(input uart_pkg::uart_byte_t d,
                                                         input logic par, input logic stop);
      if (par != parity_bit(d)) begin
         return uart_pkg::RX_PARITY_ERR;  // parity wins over a bad stop bit.
      end else if (!stop) begin
         return uart_pkg::RX_STOP_ERR;
      end
      return uart_pkg::RX_OK;
   endfunction

   task automatic check_byte(input uart_pkg::uart_byte_t got, input uart_pkg::uart_byte_t exp,
                             input string what);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("ERR %0t: %s is %02h, expected %02h", $time, what, got, exp);
      end
   endtask

   task automatic check_status(input uart_pkg::rx_status_e got,
                               input uart_pkg::rx_status_e exp, input string what);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("ERR %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      end
   endtask

   task automatic check_level(input logic got, input logic exp, input string what);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic finish_test(input string name);
      int errs;
      errs = err_count - test_err_base;
      tests_run++;
      if (errs == 0) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", name, errs);
      end
      test_err_base = err_count;
   endtask

   task automatic expect_frame(input uart_pkg::uart_byte_t d, input uart_pkg::rx_status_e st);
      rx_exp_t e;
      e.data   = d;
      e.status = st;
      exp_q.push_back(e);
   endtask

   // every receive strobe is matched against the next expected frame.
   always @(negedge clk) begin
      if (rst_n && (read_rdy || read_err)) begin
         if (exp_q.size() == 0) begin
            err_count++;
            $display("unexpected receive strobe at time %0t with no frame sent", $time);
         end else begin
            got_exp = exp_q.pop_front();
            if (read_rdy) begin
               check_status(uart_pkg::RX_OK, got_exp.status, "receive result");
               check_byte(read_data, got_exp.data, "read_data");
               last_good = got_exp.data;
            end else begin
               check_status(u_uart_top.u_rx_if.status, got_exp.status, "receive error");
               check_byte(read_data, last_good, "read_data after bad frame");
            end
         end
      end
   end

   task automatic send_cmd(input uart_pkg::uart_cmd_t c, input logic loop_rx);
      check_level(cmd_rdy, 1'b1, "cmd_rdy before command");
      cmd_in  = c;
      cmd_vld = 1'b1;
      if (loop_rx) begin
         expect_frame(c[15:8], uart_pkg::RX_OK);
         expect_frame(c[7:0], uart_pkg::RX_OK);
      end
      @(negedge clk);
      cmd_vld = 1'b0;
   endtask

   task automatic wait_ready(input string where);
      int n;
      n = 0;
      while (!cmd_rdy && n < 4 * CMD_CYCLES) begin
         @(negedge clk);
         n++;
      end
      if (!cmd_rdy) begin
         err_count++;
         $display("cmd_rdy did not return within %0d cycles in %s", n, where);
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 8 * FB * CPB) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         err_count++;
         $display("%0d expected receive strobes never arrived", exp_q.size());
         exp_q.delete();
      end
   endtask

   // samples both frames at mid-bit and the cmd_rdy level in every cycle.
   task automatic check_tx_frames(input uart_pkg::uart_cmd_t c);
      logic [2*FB-1:0] bits;
      int              b;
      bits = {frame_bits(c[15:8], parity_bit(c[15:8]), 1'b1),
              frame_bits(c[7:0], parity_bit(c[7:0]), 1'b1)};
      send_cmd(c, 1'b0);
      check_level(tx, 1'b1, "tx before start bit");
      for (int k = 1; k <= CMD_CYCLES; k++) begin
         b = (k - 2) / CPB;
         if (k >= 2 && b < 2 * FB && (k - 2) % CPB == CPB / 2) begin
            check_level(tx, bits[2*FB-1-b], $sformatf("tx bit %0d", b));
         end
         check_level(cmd_rdy, k == CMD_CYCLES, "cmd_rdy");
         if (k < CMD_CYCLES) begin
            @(negedge clk);
         end
      end
      check_level(tx, 1'b1, "tx idle after frames");
   endtask

   task automatic send_with_drops(input uart_pkg::uart_cmd_t c);
      logic [31:0] r;
      send_cmd(c, 1'b1);
      for (int k = 1; k < CMD_CYCLES; k++) begin
         if (k == 3 || k == CMD_CYCLES - 1) begin
            r       = next_random();
            cmd_in  = r[15:0];
            cmd_vld = 1'b1;  // cmd_rdy is low here.
         end else begin
            cmd_vld = 1'b0;
         end
         @(negedge clk);
      end
      cmd_vld = 1'b0;
      check_level(cmd_rdy, 1'b1, "cmd_rdy after dropped commands");
   endtask

   task automatic send_frame(input uart_pkg::uart_byte_t d, input logic par, input logic stop);
      logic [FB-1:0] bits;
      bits = frame_bits(d, par, stop);
      for (int i = FB - 1; i >= 0; i--) begin
         bb_line = bits[i];
         repeat (CPB) @(negedge clk);
      end
      bb_line = 1'b1;
      repeat (2 * CPB) @(negedge clk);
   endtask

   initial begin
      logic [31:0]          r;
      uart_pkg::uart_byte_t d;
      logic                 par;
      logic                 stop;
      clk      = 1'b0;
      rst_n    = 1'b0;
      cmd_in   = '0;
      cmd_vld  = 1'b0;
      loopback = 1'b0;
      bb_line  = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      check_level(tx, 1'b1, "tx after reset");
      check_level(cmd_rdy, 1'b1, "cmd_rdy after reset");
      check_level(read_rdy, 1'b0, "read_rdy after reset");
      check_level(read_err, 1'b0, "read_err after reset");
      finish_test("reset values");

      for (int i = 0; i < 4; i++) begin
         r = next_random();
         check_tx_frames(r[15:0]);
      end
      finish_test("frame format");

      loopback = 1'b1;
      for (int i = 0; i < NUM_LOOP; i++) begin
         r = next_random();
         send_cmd(r[15:0], 1'b1);
         wait_ready("loopback");
      end
      wait_drain();
      finish_test("loopback");

      for (int i = 0; i < 3; i++) begin
         r = next_random();
         send_with_drops(r[15:0]);
      end
      wait_drain();
      repeat (2 * FB * CPB) begin
         @(negedge clk);
         check_level(tx, 1'b1, "tx idle after dropped commands");
      end
      finish_test("dropped commands");

      loopback = 1'b0;
      for (int i = 0; i < NUM_INJ / 2; i++) begin
         r   = next_random();
         d   = r[7:0];
         par = parity_bit(d) ^ (i % 2 == 1);
         expect_frame(d, frame_status(d, par, 1'b1));
         send_frame(d, par, 1'b1);
      end
      wait_drain();
      finish_test("parity errors");

      for (int i = 0; i < NUM_INJ / 2; i++) begin
         r    = next_random();
         d    = r[7:0];
         stop = (i % 2 == 0);
         par  = parity_bit(d) ^ (i == NUM_INJ / 2 - 1);  // last one has both faults.
         expect_frame(d, frame_status(d, par, stop));
         send_frame(d, par, stop);
      end
      wait_drain();
      finish_test("stop errors");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_count, err_count);
      if (err_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_if.sv
verilog/uart_ctrl.sv
verilog/uart_tx_shifter.sv
verilog/uart_rx_deser.sv
verilog/uart_top.sv
tests/uart_properties.sv
tests/tb_uart_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_uart_top \
   -Mdir obj_dir -o sim_uart
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_uart > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
   exit 0
fi
echo "pass line not found in sim.log"
exit 1
